//--- design/axi_addr_decoder.sv
`timescale 1ns/1ps

module axi_addr_decoder
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  addr_t      awaddr,
  input  len_t       awlen,
  input  logic       awvalid,
  output logic       awready,
  input  addr_t      araddr,
  input  logic       arvalid,
  output logic       arready,
  input  logic       txn_done,
  output slv_sel_t   wr_sel,
  output slv_sel_t   rd_sel,
  output dec_state_t lock,
  axi_slv_if.decoder slv [NUM_SLAVES]
);

  slv_sel_t              aw_sel;
  slv_sel_t              ar_sel;
  logic                  aw_open;
  logic                  ar_open;
  logic [NUM_SLAVES-1:0] aw_rdy;
  logic [NUM_SLAVES-1:0] ar_rdy;
  logic                  aw_sel_rdy;
  logic                  ar_sel_rdy;

  assign aw_sel = slv_sel_t'(awaddr[7:6]);
  assign ar_sel = slv_sel_t'(araddr[7:6]);

  // AW wins over AR in the same cycle
  assign aw_open = (lock == DEC_FREE) && awvalid;
  assign ar_open = (lock == DEC_FREE) && arvalid && !awvalid;

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_fwd
    assign slv[i].awaddr  = awaddr;
    assign slv[i].awlen   = awlen;
    assign slv[i].awvalid = aw_open && (aw_sel == slv_sel_t'(i));
    assign slv[i].araddr  = araddr;
    assign slv[i].arvalid = ar_open && (ar_sel == slv_sel_t'(i));
    assign aw_rdy[i]      = slv[i].awready;
    assign ar_rdy[i]      = slv[i].arready;
  end

  // Unmapped addresses are accepted here
  always_comb begin
    aw_sel_rdy = 1'b1;
    ar_sel_rdy = 1'b1;
    if (aw_sel != SEL_UNMAPPED) begin
      aw_sel_rdy = aw_rdy[aw_sel];
    end
    if (ar_sel != SEL_UNMAPPED) begin
      ar_sel_rdy = ar_rdy[ar_sel];
    end
  end

  assign awready = aw_open && aw_sel_rdy;
  assign arready = ar_open && ar_sel_rdy;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock   <= DEC_FREE;
      wr_sel <= SEL_UNMAPPED;
      rd_sel <= SEL_UNMAPPED;
    end else if (lock == DEC_FREE) begin
      if (awvalid && awready) begin
        lock   <= DEC_WRITE;
        wr_sel <= aw_sel;
      end else if (arvalid && arready) begin
        lock   <= DEC_READ;
        rd_sel <= ar_sel;
      end
    end else if (txn_done) begin
      lock <= DEC_FREE;
    end
  end

endmodule

//--- design/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave
  import axi_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  axi_slv_if.slave  bus
);

  slave_state_t                         state;
  data_t                                mem [WORDS_PER_SLAVE];
  len_t                                 beat_cnt;
  len_t                                 len_q;
  logic [$clog2(WORDS_PER_SLAVE)-1:0]   widx;
  logic [$clog2(WORDS_PER_SLAVE)-1:0]   wr_idx;
  data_t                                rdata_q;
  logic                                 aw_hs;
  logic                                 ar_hs;
  logic                                 w_hs;
  logic                                 last_beat;

  assign bus.awready = (state == S_IDLE);
  assign bus.arready = (state == S_IDLE);
  assign bus.wready  = (state == S_WDATA);
  assign bus.bvalid  = (state == S_BRESP);
  // Every burst and every read answers OKAY
  assign bus.bresp   = RESP_OKAY;
  assign bus.rvalid  = (state == S_RDATA);
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = RESP_OKAY;

  assign aw_hs = bus.awvalid && bus.awready;
  assign ar_hs = bus.arvalid && bus.arready && !bus.awvalid;
  assign w_hs  = bus.wvalid && bus.wready;

  // Burst address wraps within the 16 words
  assign wr_idx = widx + beat_cnt;

  // Burst ends on wlast or once the count reaches awlen
  assign last_beat = bus.wlast || (beat_cnt == len_q);

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state    <= S_IDLE;
      beat_cnt <= '0;
      len_q    <= '0;
      widx     <= '0;
    end else begin
      unique case (state)
        S_IDLE: begin
          if (aw_hs) begin
            state    <= S_WDATA;
            widx     <= bus.awaddr[5:2];
            len_q    <= bus.awlen;
            beat_cnt <= '0;
          end else if (ar_hs) begin
            state <= S_RDATA;
          end
        end
        S_WDATA: begin
          if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= S_BRESP;
            end
          end
        end
        S_BRESP: begin
          if (bus.bready) begin
            state <= S_IDLE;
          end
        end
        S_RDATA: begin
          if (bus.rready) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Byte lanes under the strobes
  always_ff @(posedge clk) begin
    if (w_hs) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (bus.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read word stays put until rready
  always_ff @(posedge clk) begin
    if (ar_hs && (state == S_IDLE)) begin
      rdata_q <= mem[bus.araddr[5:2]];
    end
  end

endmodule

//--- design/axi_pkg.sv
package axi_pkg;

  // Widths
  typedef logic [7:0]  addr_t;
  typedef logic [3:0]  len_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [1:0]  slv_sel_t;

  // Address map
  localparam int NUM_SLAVES = 3;
  localparam int WORDS_PER_SLAVE = 16;
  localparam slv_sel_t SEL_UNMAPPED = 2'd3;

  // Response codes
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  typedef enum logic [1:0] {
    DEC_FREE,
    DEC_WRITE,
    DEC_READ
  } dec_state_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WDATA,
    S_BRESP,
    S_RDATA
  } slave_state_t;

endpackage

//--- design/axi_resp_collector.sv
`timescale 1ns/1ps

module axi_resp_collector
  import axi_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  slv_sel_t    wr_sel,
  input  slv_sel_t    rd_sel,
  input  dec_state_t  lock,
  input  logic        w_done,
  output resp_t       bresp,
  output logic        bvalid,
  input  logic        bready,
  output data_t       rdata,
  output resp_t       rresp,
  output logic        rvalid,
  input  logic        rready,
  output logic        txn_done,
  axi_slv_if.collector slv [NUM_SLAVES]
);

  logic [NUM_SLAVES-1:0] b_v;
  logic [NUM_SLAVES-1:0] r_v;
  resp_t                 b_r [NUM_SLAVES];
  resp_t                 r_r [NUM_SLAVES];
  data_t                 r_d [NUM_SLAVES];
  logic                  dec_pend;

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_collect
    assign b_v[i]        = slv[i].bvalid;
    assign b_r[i]        = slv[i].bresp;
    assign r_v[i]        = slv[i].rvalid;
    assign r_r[i]        = slv[i].rresp;
    assign r_d[i]        = slv[i].rdata;
    assign slv[i].bready = bready && (lock == DEC_WRITE) && (wr_sel == slv_sel_t'(i));
    assign slv[i].rready = rready && (lock == DEC_READ) && (rd_sel == slv_sel_t'(i));
  end

  always_comb begin
    bvalid = 1'b0;
    bresp  = RESP_OKAY;
    if (lock == DEC_WRITE) begin
      if (wr_sel == SEL_UNMAPPED) begin
        bvalid = dec_pend;
        bresp  = RESP_DECERR;
      end else begin
        bvalid = b_v[wr_sel];
        bresp  = b_r[wr_sel];
      end
    end
  end

  // Unmapped read answers the cycle after AR
  always_comb begin
    rvalid = 1'b0;
    rdata  = '0;
    rresp  = RESP_OKAY;
    if (lock == DEC_READ) begin
      if (rd_sel == SEL_UNMAPPED) begin
        rvalid = 1'b1;
        rresp  = RESP_DECERR;
      end else begin
        rvalid = r_v[rd_sel];
        rdata  = r_d[rd_sel];
        rresp  = r_r[rd_sel];
      end
    end
  end

  assign txn_done = (bvalid && bready) || (rvalid && rready);

  // Last sunk beat arms the DECERR write response
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      dec_pend <= 1'b0;
    end else if (w_done) begin
      dec_pend <= 1'b1;
    end else if (txn_done) begin
      dec_pend <= 1'b0;
    end
  end

endmodule

//--- design/axi_slv_if.sv
`timescale 1ns/1ps

interface axi_slv_if
  import axi_pkg::*;
();

  addr_t awaddr;
  len_t  awlen;
  logic  awvalid;
  logic  awready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t wdata;
  strb_t wstrb;
  logic  wlast;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  modport decoder (
    output awaddr, awlen, awvalid, araddr, arvalid,
    input  awready, arready
  );

  modport router (
    output wdata, wstrb, wlast, wvalid,
    input  wready
  );

  modport collector (
    input  bresp, bvalid, rdata, rresp, rvalid,
    output bready, rready
  );

  modport slave (
    input  awaddr, awlen, awvalid, araddr, arvalid,
    input  wdata, wstrb, wlast, wvalid,
    input  bready, rready,
    output awready, arready, wready,
    output bresp, bvalid, rdata, rresp, rvalid
  );

endinterface

//--- design/axi_w_router.sv
`timescale 1ns/1ps

module axi_w_router
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  addr_t      awaddr,
  input  logic       awvalid,
  input  data_t      wdata,
  input  strb_t      wstrb,
  input  logic       wlast,
  input  logic       wvalid,
  output logic       wready,
  input  slv_sel_t   wr_sel,
  input  dec_state_t lock,
  output logic       w_done,
  axi_slv_if.router  slv [NUM_SLAVES]
);

  logic                  fast_path;
  logic                  slow_path;
  logic                  w_route;
  logic                  burst_done;
  logic                  w_hs;
  slv_sel_t              w_sel;
  logic [NUM_SLAVES-1:0] w_rdy;

  // AW and W together, steer by the live address
  assign fast_path = (lock == DEC_FREE) && awvalid && wvalid;
  // W after AW, steer by the select taken at the AW handshake
  assign slow_path = (lock == DEC_WRITE) && !burst_done;
  assign w_route   = fast_path || slow_path;
  assign w_sel     = fast_path ? slv_sel_t'(awaddr[7:6]) : wr_sel;

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_route
    logic hit;
    assign hit          = w_route && (w_sel == slv_sel_t'(i));
    assign slv[i].wdata  = hit ? wdata : '0;
    assign slv[i].wstrb  = hit ? wstrb : '0;
    assign slv[i].wlast  = hit && wlast;
    assign slv[i].wvalid = hit && wvalid;
    assign w_rdy[i]      = slv[i].wready;
  end

  always_comb begin
    wready = 1'b0;
    if (w_route) begin
      if (w_sel == SEL_UNMAPPED) begin
        // Sink beats nobody owns
        wready = 1'b1;
      end else begin
        wready = w_rdy[w_sel];
      end
    end
  end

  assign w_hs   = wvalid && wready;
  assign w_done = w_hs && wlast && (w_sel == SEL_UNMAPPED);

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      burst_done <= 1'b0;
    end else if (w_hs && wlast) begin
      burst_done <= 1'b1;
    end else if (lock == DEC_FREE) begin
      burst_done <= 1'b0;
    end
  end

endmodule

//--- design/axi_xbar_top.sv
`timescale 1ns/1ps

module axi_xbar_top
  import axi_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  addr_t awaddr,
  input  len_t  awlen,
  input  logic  awvalid,
  output logic  awready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wlast,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready
);

  slv_sel_t   wr_sel;
  slv_sel_t   rd_sel;
  dec_state_t lock;
  logic       w_done;
  logic       txn_done;

  axi_slv_if slv_if [NUM_SLAVES] ();

  axi_addr_decoder decoder_i (
    .clk      (clk),
    .rstn     (rstn),
    .awaddr   (awaddr),
    .awlen    (awlen),
    .awvalid  (awvalid),
    .awready  (awready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .txn_done (txn_done),
    .wr_sel   (wr_sel),
    .rd_sel   (rd_sel),
    .lock     (lock),
    .slv      (slv_if)
  );

  axi_w_router router_i (
    .clk     (clk),
    .rstn    (rstn),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .wr_sel  (wr_sel),
    .lock    (lock),
    .w_done  (w_done),
    .slv     (slv_if)
  );

  axi_resp_collector collector_i (
    .clk      (clk),
    .rstn     (rstn),
    .wr_sel   (wr_sel),
    .rd_sel   (rd_sel),
    .lock     (lock),
    .w_done   (w_done),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .txn_done (txn_done),
    .slv      (slv_if)
  );

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
    axi_mem_slave slave_i (
      .clk  (clk),
      .rstn (rstn),
      .bus  (slv_if[i])
    );
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -Mdir obj_dir -o tb_sim -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
  import axi_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  addr_t awaddr,
  input  logic  awvalid,
  input  logic  awready,
  input  logic  wlast,
  input  logic  wvalid,
  input  logic  wready,
  input  resp_t bresp,
  input  logic  bvalid,
  input  logic  bready,
  input  addr_t araddr,
  input  logic  arvalid,
  input  logic  arready,
  input  data_t rdata,
  input  resp_t rresp,
  input  logic  rvalid,
  input  logic  rready,
  input  data_t model [NUM_SLAVES][WORDS_PER_SLAVE],
  input  logic  final_check,
  output int    errors,
  output int    responses
);

  addr_t addr_q [$];
  logic  read_q [$];
  resp_t resp_q [$];
  data_t data_q [$];
  int    accepted;
  logic  last_w_q;
  logic  ar_hs_q;
  logic  bvalid_q;
  logic  rvalid_q;

  // One expected response per accepted address
  task automatic expect_response(input addr_t addr, input logic is_read);
    slv_sel_t sel;
    sel = slv_sel_t'(addr[7:6]);
    addr_q.push_back(addr);
    read_q.push_back(is_read);
    resp_q.push_back((sel == SEL_UNMAPPED) ? RESP_DECERR : RESP_OKAY);
    if (is_read && (sel != SEL_UNMAPPED)) begin
      data_q.push_back(model[sel][addr[5:2]]);
    end else begin
      data_q.push_back('0);
    end
    accepted++;
  endtask

  task automatic compare_response(input logic is_read, input resp_t resp, input data_t data);
    addr_t addr;
    logic  exp_read;
    resp_t exp_resp;
    data_t exp_data;
    if (addr_q.size() == 0) begin
      $display("A response arrived with no address pending (read=%0d)", is_read);
      errors++;
      return;
    end
    addr     = addr_q.pop_front();
    exp_read = read_q.pop_front();
    exp_resp = resp_q.pop_front();
    exp_data = data_q.pop_front();
    responses++;
    if (exp_read != is_read) begin
      $display("Response type does not match the pending address 0x%02h", addr);
      errors++;
    end else if (resp !== exp_resp) begin
      $display("Error at %0t ns: response to 0x%02h is %0d, expected %0d",
               $time, addr, resp, exp_resp);
      errors++;
    end else if (is_read && (data !== exp_data)) begin
      $display("Error at %0t ns: read of 0x%02h returned 0x%08h, expected 0x%08h",
               $time, addr, data, exp_data);
      errors++;
    end
  endtask

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      addr_q.delete();
      read_q.delete();
      resp_q.delete();
      data_q.delete();
      errors    = 0;
      responses = 0;
      accepted  = 0;
      last_w_q  = 1'b0;
      ar_hs_q   = 1'b0;
      bvalid_q  = 1'b0;
      rvalid_q  = 1'b0;
    end else begin
      if (awvalid && awready) begin
        expect_response(awaddr, 1'b0);
      end
      if (arvalid && arready) begin
        expect_response(araddr, 1'b1);
      end
      if (bvalid && bready) begin
        compare_response(1'b0, bresp, '0);
      end
      if (rvalid && rready) begin
        compare_response(1'b1, rresp, rdata);
      end
      // Responses rise exactly one cycle after their trigger
      if (last_w_q != (bvalid && !bvalid_q)) begin
        $display("Error at %0t ns: bvalid did not follow the last W beat by one cycle", $time);
        errors++;
      end
      if (ar_hs_q != (rvalid && !rvalid_q)) begin
        $display("Error at %0t ns: rvalid did not follow the AR handshake by one cycle", $time);
        errors++;
      end
      if (final_check && ((accepted != responses) || (addr_q.size() != 0))) begin
        $display("%0d addresses were accepted but %0d responses were seen",
                 accepted, responses);
        errors++;
      end
      last_w_q = wvalid && wready && wlast;
      ar_hs_q  = arvalid && arready;
      bvalid_q = bvalid;
      rvalid_q = rvalid;
    end
  end

endmodule

//--- testbench/tb_properties.sv
`timescale 1ns/1ps

module xbar_properties
  import axi_pkg::*;
(
  input logic  clk,
  input logic  rstn,
  input logic  awready,
  input logic  arready,
  input resp_t bresp,
  input logic  bvalid,
  input logic  bready,
  input data_t rdata,
  input resp_t rresp,
  input logic  rvalid,
  input logic  rready
);

  // B holds until the master takes it
  b_hold: assert property (@(posedge clk) disable iff (!rstn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid dropped or bresp changed before bready");

  r_hold: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("rvalid dropped or read payload changed before rready");

  // Lock keeps the address channels shut
  no_addr_while_resp: assert property (@(posedge clk) disable iff (!rstn)
    (bvalid || rvalid) |-> !awready && !arready)
    else $error("Address accepted while a response is pending");

  resp_low_in_reset: assert property (@(posedge clk)
    !rstn |-> !bvalid && !rvalid)
    else $error("Response valid high during reset");

endmodule

bind axi_xbar_top xbar_properties props_i (
  .clk     (clk),
  .rstn    (rstn),
  .awready (awready),
  .arready (arready),
  .bresp   (bresp),
  .bvalid  (bvalid),
  .bready  (bready),
  .rdata   (rdata),
  .rresp   (rresp),
  .rvalid  (rvalid),
  .rready  (rready)
);

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import axi_pkg::*;
();

  logic        clk;
  logic        rstn;
  addr_t       awaddr;
  len_t        awlen;
  logic        awvalid;
  logic        awready;
  data_t       wdata;
  strb_t       wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  resp_t       bresp;
  logic        bvalid;
  logic        bready;
  addr_t       araddr;
  logic        arvalid;
  logic        arready;
  data_t       rdata;
  resp_t       rresp;
  logic        rvalid;
  logic        rready;
  logic        final_check;
  int          errors;
  int          responses;
  int          timeouts;
  int          txns;
  logic [15:0] lfsr;
  data_t       model [NUM_SLAVES][WORDS_PER_SLAVE];

  axi_xbar_top dut_i (.*);

  tb_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic update_model(input addr_t addr, input int beat, input data_t data,
                              input strb_t strb);
    slv_sel_t   sel;
    logic [3:0] idx;
    sel = slv_sel_t'(addr[7:6]);
    idx = addr[5:2] + 4'(beat);
    if (sel != SEL_UNMAPPED) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[sel][idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic present_beat(input int beat, input len_t len, input logic full);
    wdata  <= rand_bits(32);
    wstrb  <= full ? 4'hf : strb_t'(rand_bits(4));
    wlast  <= (beat == int'(len));
    wvalid <= 1'b1;
  endtask

  // Fast path puts beat 0 up together with AW
  task automatic drive_write(input addr_t addr, input len_t len, input logic fast,
                             input logic full);
    int   beat;
    int   cycles;
    logic aw_done;
    logic w_busy;
    logic w_done;
    logic b_done;
    if (timeouts != 0) return;
    beat    = 0;
    cycles  = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    w_busy  = fast;
    txns++;
    awaddr  <= addr;
    awlen   <= len;
    awvalid <= 1'b1;
    if (fast) begin
      present_beat(0, len, full);
    end
    while (!b_done) begin
      @(posedge clk);
      cycles++;
      if (awvalid && awready) begin
        aw_done = 1'b1;
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        update_model(addr, beat, wdata, wstrb);
        w_done = wlast;
        w_busy = 1'b0;
        beat++;
        wvalid <= 1'b0;
      end
      if (bvalid && bready) begin
        b_done = 1'b1;
        bready <= 1'b0;
      end else if (w_done) begin
        bready <= (rand_bits(2) != 0);
      end
      // Next beat, or a gap cycle
      if (aw_done && !w_done && !w_busy && (rand_bits(2) != 0)) begin
        present_beat(beat, len, full);
        w_busy = 1'b1;
      end
      if (!b_done && (cycles > 200)) begin
        $display("Timeout: write to address 0x%02h did not finish within 200 cycles", addr);
        timeouts++;
        break;
      end
    end
  endtask

  task automatic drive_read(input addr_t addr);
    int   cycles;
    logic r_done;
    if (timeouts != 0) return;
    cycles = 0;
    r_done = 1'b0;
    txns++;
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= (rand_bits(2) != 0);
    while (!r_done) begin
      @(posedge clk);
      cycles++;
      if (arvalid && arready) begin
        arvalid <= 1'b0;
      end
      if (rvalid && rready) begin
        r_done = 1'b1;
        rready <= 1'b0;
      end else begin
        rready <= (rand_bits(2) != 0);
      end
      if (!r_done && (cycles > 200)) begin
        $display("Timeout: read of address 0x%02h did not finish within 200 cycles", addr);
        timeouts++;
        break;
      end
    end
  endtask

  // Slave 3 about one time in eight
  task automatic random_txn();
    slv_sel_t   sel;
    logic [3:0] word;
    addr_t      addr;
    len_t       len;
    logic       is_write;
    logic       fast;
    if (rand_bits(3) == 0) begin
      sel = SEL_UNMAPPED;
    end else begin
      sel = slv_sel_t'(rand_bits(2) % NUM_SLAVES);
    end
    word     = 4'(rand_bits(4));
    addr     = {sel, word, 2'b00};
    is_write = rand_bits(1) != 0;
    len      = len_t'(rand_bits(4));
    fast     = rand_bits(1) != 0;
    if (is_write) begin
      drive_write(addr, len, fast, 1'b0);
    end else begin
      drive_read(addr);
    end
  endtask

  initial begin
    rstn        = 1'b0;
    awaddr      = '0;
    awlen       = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wlast       = 1'b0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    final_check = 1'b0;
    timeouts    = 0;
    txns        = 0;
    lfsr        = 16'd44378;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      for (int w = 0; w < WORDS_PER_SLAVE; w++) begin
        model[s][w] = '0;
      end
    end
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    // Fill every word so that no read sees an unwritten location
    for (int s = 0; s < NUM_SLAVES; s++) begin
      drive_write(addr_t'(s * 64), 4'd15, (s % 2) == 1, 1'b1);
    end
    for (int s = 0; s < NUM_SLAVES; s++) begin
      drive_write(addr_t'(s * 64 + 4 * (s + 5)), 4'd0, 1'b1, 1'b1);
      drive_read(addr_t'(s * 64 + 4 * (s + 5)));
    end
    drive_write(8'hc4, 4'd2, 1'b1, 1'b0);
    drive_write(8'hf0, 4'd0, 1'b0, 1'b1);
    drive_read(8'hc4);
    // Burst on slave 1 that wraps past word 15
    drive_write(8'h78, 4'd7, 1'b0, 1'b0);
    drive_read(8'h44);
    for (int n = 0; n < 300; n++) begin
      random_txn();
    end
    final_check <= 1'b1;
    @(posedge clk);
    final_check <= 1'b0;
    repeat (2) @(posedge clk);
    $display("Run complete: %0d transactions, %0d responses checked, %0d errors, %0d timeouts",
             txns, responses, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/axi_pkg.sv
design/axi_slv_if.sv
design/axi_addr_decoder.sv
design/axi_w_router.sv
design/axi_mem_slave.sv
design/axi_resp_collector.sv
design/axi_xbar_top.sv
testbench/tb_properties.sv
testbench/tb_checker.sv
testbench/tb_top.sv
